// ==== source/lane_pkg.sv ====
// Lane overlay shared definitions

package lane_pkg;

    // ----------------------------------------
    // Lane geometry
    // ----------------------------------------
    // Engines in the processing chain
    localparam int NUM_ENGINES = 4;
    // Lane data and memory write data
    localparam int DATA_W = 32;
    // Packet tag, also the job packet count
    localparam int TAG_W = 8;
    // Memory address
    localparam int ADDR_W = 32;
    // Engine id carried on the memory port
    localparam int ENG_ID_W = 2;

    // ----------------------------------------
    // Write request queue
    // ----------------------------------------
    // Entries per engine, kept a power of two
    localparam int REQ_QUEUE_DEPTH = 4;
    // Queue pointer width
    localparam int REQ_PTR_W = $clog2(REQ_QUEUE_DEPTH);

    // Job opcode
    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_ADD  = 2'd1,
        OP_XOR  = 2'd2
    } lane_op_e;

    // Job control state
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } lane_state_e;

endpackage

// ==== source/lane_ctrl.sv ====
// Lane job control
`timescale 1ns/1ps

module lane_ctrl (
    input  logic                                 ap_clk,
    input  logic                                 areset_lane_template,
    // Job descriptor, sampled on the start strobe
    input  logic                                 start_i,
    input  lane_pkg::lane_op_e                   op_i,
    input  logic [lane_pkg::DATA_W-1:0]          operand_i,
    input  logic [lane_pkg::ADDR_W-1:0]          base_addr_i,
    input  logic [lane_pkg::TAG_W-1:0]           count_i,
    // Lane input packets
    input  logic                                 lane_valid_i,
    input  logic [lane_pkg::DATA_W-1:0]          lane_data_i,
    input  logic [lane_pkg::TAG_W-1:0]           lane_tag_i,
    // Chain status
    input  logic                                 out_valid_i,
    input  logic [lane_pkg::NUM_ENGINES-1:0]     engines_idle_i,
    // Descriptor fanned out to the engines
    output lane_pkg::lane_op_e                   op_o,
    output logic [lane_pkg::DATA_W-1:0]          operand_o,
    output logic [lane_pkg::ADDR_W-1:0]          base_addr_o,
    // Registered packet into engine 0
    output logic                                 stage_valid_o,
    output logic [lane_pkg::DATA_W-1:0]          stage_data_o,
    output logic [lane_pkg::TAG_W-1:0]           stage_tag_o,
    output logic                                 done_o
);

    import lane_pkg::*;

    lane_state_e        state_q;
    logic [TAG_W-1:0]   count_q;
    logic [TAG_W-1:0]   out_cnt_q;
    logic               job_complete;

    // Every packet out of the chain and every write acknowledged
    assign job_complete = (out_cnt_q == count_q) && (&engines_idle_i);

    // ----------------------------------------
    // Job state machine
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            state_q   <= ST_IDLE;
            out_cnt_q <= '0;
            done_o    <= 1'b0;
        end else begin
            case (state_q)
                ST_RUN: begin
                    if (out_valid_i) begin
                        out_cnt_q <= out_cnt_q + 1'b1;
                    end
                    if (job_complete) begin
                        state_q <= ST_DONE;
                        done_o  <= 1'b1;
                    end
                end
                default: begin
                    // Idle or done, wait for the next job
                    if (start_i) begin
                        state_q   <= ST_RUN;
                        out_cnt_q <= '0;
                        done_o    <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Descriptor latch
    always_ff @(posedge ap_clk) begin
        if (start_i && (state_q != ST_RUN)) begin
            op_o        <= op_i;
            operand_o   <= operand_i;
            base_addr_o <= base_addr_i;
            count_q     <= count_i;
        end
    end

    // ----------------------------------------
    // Input stage
    // ----------------------------------------
    // Packets outside a running job are dropped here
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            stage_valid_o <= 1'b0;
        end else begin
            stage_valid_o <= lane_valid_i && (state_q == ST_RUN);
        end
    end

    always_ff @(posedge ap_clk) begin
        stage_data_o <= lane_data_i;
        stage_tag_o  <= lane_tag_i;
    end

endmodule

// ==== source/lane_engine.sv ====
// Lane chain engine
`timescale 1ns/1ps

module lane_engine #(
    parameter int unsigned ENGINE_ID = 0
) (
    input  logic                          ap_clk,
    input  logic                          areset_lane_template,
    // Job descriptor
    input  lane_pkg::lane_op_e            op_i,
    input  logic [lane_pkg::DATA_W-1:0]   operand_i,
    input  logic [lane_pkg::ADDR_W-1:0]   base_addr_i,
    // Chain input
    input  logic                          in_valid_i,
    input  logic [lane_pkg::DATA_W-1:0]   in_data_i,
    input  logic [lane_pkg::TAG_W-1:0]    in_tag_i,
    // Chain output
    output logic                          out_valid_o,
    output logic [lane_pkg::DATA_W-1:0]   out_data_o,
    output logic [lane_pkg::TAG_W-1:0]    out_tag_o,
    // Write request head
    output logic                          req_pending_o,
    output logic [lane_pkg::ADDR_W-1:0]   req_addr_o,
    output logic [lane_pkg::DATA_W-1:0]   req_data_o,
    input  logic                          grant_i,
    input  logic                          ack_i,
    output logic                          idle_o
);

    import lane_pkg::*;

    logic [DATA_W-1:0]      result;
    logic [ADDR_W-1:0]      wr_addr;
    logic [ADDR_W-1:0]      q_addr [REQ_QUEUE_DEPTH];
    logic [DATA_W-1:0]      q_data [REQ_QUEUE_DEPTH];
    logic [REQ_PTR_W-1:0]   wr_ptr_q;
    logic [REQ_PTR_W-1:0]   rd_ptr_q;
    logic [REQ_PTR_W:0]     fill_q;
    logic [TAG_W-1:0]       outstanding_q;
    logic                   pop;

    // ----------------------------------------
    // Opcode datapath
    // ----------------------------------------
    always_comb begin
        case (op_i)
            OP_ADD:  result = in_data_i + operand_i;
            OP_XOR:  result = in_data_i ^ (operand_i + DATA_W'(ENGINE_ID));
            default: result = in_data_i;
        endcase
    end

    // One word per engine per tag
    assign wr_addr = base_addr_i
                   + (ADDR_W'(in_tag_i) * ADDR_W'(NUM_ENGINES))
                   + ADDR_W'(ENGINE_ID);

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        out_data_o <= result;
        out_tag_o  <= in_tag_i;
    end

    // ----------------------------------------
    // Write request queue
    // ----------------------------------------
    assign req_pending_o = (fill_q != '0);
    assign pop           = grant_i && req_pending_o;
    assign req_addr_o    = q_addr[rd_ptr_q];
    assign req_data_o    = q_data[rd_ptr_q];

    // Storage written alongside the output register
    always_ff @(posedge ap_clk) begin
        if (in_valid_i) begin
            q_addr[wr_ptr_q] <= wr_addr;
            q_data[wr_ptr_q] <= result;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (in_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({in_valid_i, pop})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
        end
    end

    // Writes issued to memory but not yet acknowledged
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            outstanding_q <= '0;
        end else begin
            case ({pop, ack_i})
                2'b10:   outstanding_q <= outstanding_q + 1'b1;
                2'b01:   outstanding_q <= outstanding_q - 1'b1;
                default: outstanding_q <= outstanding_q;
            endcase
        end
    end

    assign idle_o = (fill_q == '0) && (outstanding_q == '0);

endmodule

// ==== source/mem_port.sv ====
// Shared memory port arbiter
`timescale 1ns/1ps

module mem_port (
    input  logic                                ap_clk,
    input  logic                                areset_lane_template,
    // Engine write requests
    input  logic [lane_pkg::NUM_ENGINES-1:0]    req_pending_i,
    input  logic [lane_pkg::ADDR_W-1:0]         req_addr_i [lane_pkg::NUM_ENGINES],
    input  logic [lane_pkg::DATA_W-1:0]         req_data_i [lane_pkg::NUM_ENGINES],
    output logic [lane_pkg::NUM_ENGINES-1:0]    grant_o,
    // Memory request channel
    output logic                                mem_req_valid_o,
    output logic [lane_pkg::ADDR_W-1:0]         mem_req_addr_o,
    output logic [lane_pkg::DATA_W-1:0]         mem_req_data_o,
    output logic [lane_pkg::ENG_ID_W-1:0]       mem_req_id_o,
    // Memory acknowledgement channel
    input  logic                                mem_ack_valid_i,
    input  logic [lane_pkg::ENG_ID_W-1:0]       mem_ack_id_i,
    output logic [lane_pkg::NUM_ENGINES-1:0]    ack_o
);

    import lane_pkg::*;

    logic [ENG_ID_W-1:0]    last_q;
    logic [ENG_ID_W-1:0]    grant_id;
    logic                   grant_any;
    int unsigned            scan_idx;
    logic                   ack_valid_q;
    logic [ENG_ID_W-1:0]    ack_id_q;

    // ----------------------------------------
    // Round-robin pick
    // ----------------------------------------
    // Scan starts just after the engine served last
    always_comb begin
        grant_o   = '0;
        grant_id  = last_q;
        grant_any = 1'b0;
        scan_idx  = 0;
        for (int k = 1; k <= NUM_ENGINES; k++) begin
            scan_idx = (int'(last_q) + k) % NUM_ENGINES;
            if (!grant_any && req_pending_i[scan_idx]) begin
                grant_any         = 1'b1;
                grant_id          = ENG_ID_W'(scan_idx);
                grant_o[scan_idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            // Engine 0 gets first pick after reset
            last_q <= ENG_ID_W'(NUM_ENGINES - 1);
        end else if (grant_any) begin
            last_q <= grant_id;
        end
    end

    // ----------------------------------------
    // Request register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            mem_req_valid_o <= 1'b0;
        end else begin
            mem_req_valid_o <= grant_any;
        end
    end

    // Granted engine pops in this same cycle
    always_ff @(posedge ap_clk) begin
        if (grant_any) begin
            mem_req_addr_o <= req_addr_i[grant_id];
            mem_req_data_o <= req_data_i[grant_id];
            mem_req_id_o   <= grant_id;
        end
    end

    // ----------------------------------------
    // Acknowledgement routing
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            ack_valid_q <= 1'b0;
        end else begin
            ack_valid_q <= mem_ack_valid_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        ack_id_q <= mem_ack_id_i;
    end

    // One-hot strobe to the issuing engine
    always_comb begin
        ack_o = '0;
        if (ack_valid_q) begin
            ack_o[ack_id_q] = 1'b1;
        end
    end

endmodule

// ==== source/lane_overlay.sv ====
// Lane overlay top level
`timescale 1ns/1ps

module lane_overlay (
    input  logic                            ap_clk,
    input  logic                            areset_lane_template,
    // Job descriptor
    input  logic                            start_i,
    input  lane_pkg::lane_op_e              op_i,
    input  logic [lane_pkg::DATA_W-1:0]     operand_i,
    input  logic [lane_pkg::ADDR_W-1:0]     base_addr_i,
    input  logic [lane_pkg::TAG_W-1:0]      count_i,
    // Lane input
    input  logic                            lane_valid_i,
    input  logic [lane_pkg::DATA_W-1:0]     lane_data_i,
    input  logic [lane_pkg::TAG_W-1:0]      lane_tag_i,
    // Lane output
    output logic                            lane_out_valid_o,
    output logic [lane_pkg::DATA_W-1:0]     lane_out_data_o,
    output logic [lane_pkg::TAG_W-1:0]      lane_out_tag_o,
    // Shared memory port
    output logic                            mem_req_valid_o,
    output logic [lane_pkg::ADDR_W-1:0]     mem_req_addr_o,
    output logic [lane_pkg::DATA_W-1:0]     mem_req_data_o,
    output logic [lane_pkg::ENG_ID_W-1:0]   mem_req_id_o,
    input  logic                            mem_ack_valid_i,
    input  logic [lane_pkg::ENG_ID_W-1:0]   mem_ack_id_i,
    output logic                            done_o
);

    import lane_pkg::*;

    // Descriptor held for the job
    lane_op_e               job_op;
    logic [DATA_W-1:0]      job_operand;
    logic [ADDR_W-1:0]      job_base_addr;

    // Chain links, entry 0 from control, last to the output
    logic [NUM_ENGINES:0]   chain_valid;
    logic [DATA_W-1:0]      chain_data [NUM_ENGINES+1];
    logic [TAG_W-1:0]       chain_tag  [NUM_ENGINES+1];

    // Engine side of the memory port
    logic [NUM_ENGINES-1:0] engines_idle;
    logic [NUM_ENGINES-1:0] req_pending;
    logic [ADDR_W-1:0]      req_addr [NUM_ENGINES];
    logic [DATA_W-1:0]      req_data [NUM_ENGINES];
    logic [NUM_ENGINES-1:0] grant;
    logic [NUM_ENGINES-1:0] ack;

    assign lane_out_valid_o = chain_valid[NUM_ENGINES];
    assign lane_out_data_o  = chain_data[NUM_ENGINES];
    assign lane_out_tag_o   = chain_tag[NUM_ENGINES];

    // ----------------------------------------
    // Job control
    // ----------------------------------------
    lane_ctrl u_ctrl (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .start_i              (start_i),
        .op_i                 (op_i),
        .operand_i            (operand_i),
        .base_addr_i          (base_addr_i),
        .count_i              (count_i),
        .lane_valid_i         (lane_valid_i),
        .lane_data_i          (lane_data_i),
        .lane_tag_i           (lane_tag_i),
        .out_valid_i          (chain_valid[NUM_ENGINES]),
        .engines_idle_i       (engines_idle),
        .op_o                 (job_op),
        .operand_o            (job_operand),
        .base_addr_o          (job_base_addr),
        .stage_valid_o        (chain_valid[0]),
        .stage_data_o         (chain_data[0]),
        .stage_tag_o          (chain_tag[0]),
        .done_o               (done_o)
    );

    // ----------------------------------------
    // Engine chain
    // ----------------------------------------
    for (genvar g = 0; g < NUM_ENGINES; g++) begin : g_engine
        lane_engine #(
            .ENGINE_ID (g)
        ) u_engine (
            .ap_clk               (ap_clk),
            .areset_lane_template (areset_lane_template),
            .op_i                 (job_op),
            .operand_i            (job_operand),
            .base_addr_i          (job_base_addr),
            .in_valid_i           (chain_valid[g]),
            .in_data_i            (chain_data[g]),
            .in_tag_i             (chain_tag[g]),
            .out_valid_o          (chain_valid[g+1]),
            .out_data_o           (chain_data[g+1]),
            .out_tag_o            (chain_tag[g+1]),
            .req_pending_o        (req_pending[g]),
            .req_addr_o           (req_addr[g]),
            .req_data_o           (req_data[g]),
            .grant_i              (grant[g]),
            .ack_i                (ack[g]),
            .idle_o               (engines_idle[g])
        );
    end

    // Shared write port
    mem_port u_mem_port (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .req_pending_i        (req_pending),
        .req_addr_i           (req_addr),
        .req_data_i           (req_data),
        .grant_o              (grant),
        .mem_req_valid_o      (mem_req_valid_o),
        .mem_req_addr_o       (mem_req_addr_o),
        .mem_req_data_o       (mem_req_data_o),
        .mem_req_id_o         (mem_req_id_o),
        .mem_ack_valid_i      (mem_ack_valid_i),
        .mem_ack_id_i         (mem_ack_id_i),
        .ack_o                (ack)
    );

endmodule

// ==== sim/lane_overlay_sva.sv ====
// Memory port assertions
`timescale 1ns/1ps

module lane_overlay_sva (
    input logic                               ap_clk,
    input logic                               areset_lane_template,
    input logic [lane_pkg::NUM_ENGINES-1:0]   grant_o,
    input logic                               mem_req_valid_o,
    input logic [lane_pkg::ENG_ID_W-1:0]      mem_req_id_o
);

    import lane_pkg::*;

    // At most one engine served per cycle
    a_grant_onehot: assert property (
        @(posedge ap_clk) disable iff (areset_lane_template)
        $onehot0(grant_o)
    ) else $error("grant_o has more than one engine selected");

    // Request register held clear by reset
    a_no_req_in_reset: assert property (
        @(posedge ap_clk) areset_lane_template |=> !mem_req_valid_o
    ) else $error("mem_req_valid_o raised while reset was active");

    // Id names an existing engine, the one granted in the cycle before
    a_req_id_range: assert property (
        @(posedge ap_clk) disable iff (areset_lane_template)
        mem_req_valid_o |-> (int'(mem_req_id_o) < NUM_ENGINES)
            && ($past(grant_o) == (NUM_ENGINES'(1) << mem_req_id_o))
    ) else $error("mem_req_id_o does not name the granted engine");

endmodule

bind mem_port lane_overlay_sva u_sva (
    .ap_clk               (ap_clk),
    .areset_lane_template (areset_lane_template),
    .grant_o              (grant_o),
    .mem_req_valid_o      (mem_req_valid_o),
    .mem_req_id_o         (mem_req_id_o)
);

// ==== sim/lane_overlay_tb.sv ====
// Lane overlay testbench
`timescale 1ns/1ps

module lane_overlay_tb;

    import lane_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_JOBS   = 4;
    // Idle cycles after each lane packet, at least the engine count
    localparam int PKT_GAP    = NUM_ENGINES;

    // Job row: descriptor plus expected number of memory writes
    typedef struct packed {
        lane_op_e           op;
        logic [DATA_W-1:0]  operand;
        logic [ADDR_W-1:0]  base;
        logic [TAG_W-1:0]   count;
        logic [15:0]        writes;
    } job_t;

    logic                   ap_clk = 1'b0;
    logic                   areset_lane_template;
    logic                   start_i;
    lane_op_e               op_i;
    logic [DATA_W-1:0]      operand_i;
    logic [ADDR_W-1:0]      base_addr_i;
    logic [TAG_W-1:0]       count_i;
    logic                   lane_valid_i;
    logic [DATA_W-1:0]      lane_data_i;
    logic [TAG_W-1:0]       lane_tag_i;
    logic                   lane_out_valid_o;
    logic [DATA_W-1:0]      lane_out_data_o;
    logic [TAG_W-1:0]       lane_out_tag_o;
    logic                   mem_req_valid_o;
    logic [ADDR_W-1:0]      mem_req_addr_o;
    logic [DATA_W-1:0]      mem_req_data_o;
    logic [ENG_ID_W-1:0]    mem_req_id_o;
    logic                   mem_ack_valid_i;
    logic [ENG_ID_W-1:0]    mem_ack_id_i;
    logic                   done_o;

    job_t                   job_table [NUM_JOBS];
    bit                     table_loaded = 1'b0;
    bit                     job_busy = 1'b0;
    int unsigned            cycle = 0;
    int unsigned            writes_seen = 0;
    // Separate LFSR streams for packet data and ack delay
    logic [31:0]            lfsr_data = 32'h50d8;
    logic [31:0]            lfsr_ack = 32'h50d8;

    // Scoreboard of outputs in order, writes by address
    logic [DATA_W-1:0]      exp_out_data [$];
    logic [TAG_W-1:0]       exp_out_tag [$];
    int unsigned            exp_out_cycle [$];
    logic [DATA_W-1:0]      exp_wr_data [logic [ADDR_W-1:0]];
    logic [ENG_ID_W-1:0]    exp_wr_id [logic [ADDR_W-1:0]];
    logic [ENG_ID_W-1:0]    ack_q [$];

    lane_overlay u_dut (.*);

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    always @(posedge ap_clk) cycle <= cycle + 1;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic fail_run();
        $display("sim failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp) else begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        assert (ok) else begin
            $display("%s at %0t ns", what, $time);
            fail_run();
        end
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val   = {val[30:0], state[0]};
            state = lfsr_next(state);
        end
    endtask

    // Single engine stage per the opcode rules
    function automatic logic [DATA_W-1:0] engine_model(input lane_op_e op,
            input logic [DATA_W-1:0] operand, input logic [DATA_W-1:0] data,
            input int unsigned id);
        case (op)
            OP_ADD:  return data + operand;
            OP_XOR:  return data ^ (operand + DATA_W'(id));
            default: return data;
        endcase
    endfunction

    task automatic load_job_table();
        // op, operand, base address, packets, expected writes
        job_table[0] = '{OP_PASS, 32'h0000_0000, 32'h0000_1000, 8'd3, 16'd12};
        job_table[1] = '{OP_ADD,  32'h0000_0011, 32'h0000_2000, 8'd5, 16'd20};
        job_table[2] = '{OP_XOR,  32'hA5A5_0F0F, 32'h0000_3000, 8'd4, 16'd16};
        job_table[3] = '{OP_ADD,  32'hFFFF_FFF0, 32'h0000_4000, 8'd6, 16'd24};
        table_loaded = 1'b1;
    endtask

    // One lane packet, expected results queued only inside a job
    task automatic send_packet(input job_t job, input logic [TAG_W-1:0] tag, input bit in_job);
        logic [31:0]        data;
        logic [DATA_W-1:0]  value;
        logic [ADDR_W-1:0]  addr;
        draw_bits(lfsr_data, DATA_W, data);
        @(posedge ap_clk);
        lane_valid_i <= 1'b1;
        lane_data_i  <= data;
        lane_tag_i   <= tag;
        @(negedge ap_clk);
        if (in_job) begin
            value = data;
            for (int k = 0; k < NUM_ENGINES; k++) begin
                value = engine_model(job.op, job.operand, value, k);
                addr  = job.base + ADDR_W'(tag) * ADDR_W'(NUM_ENGINES) + ADDR_W'(k);
                exp_wr_data[addr] = value;
                exp_wr_id[addr]   = ENG_ID_W'(k);
            end
            exp_out_data.push_back(value);
            exp_out_tag.push_back(tag);
            exp_out_cycle.push_back(cycle + NUM_ENGINES + 1);
        end
        @(posedge ap_clk);
        lane_valid_i <= 1'b0;
        repeat (PKT_GAP) @(posedge ap_clk);
    endtask

    // Packets with no job running must vanish
    task automatic send_dropped(input int n);
        for (int p = 0; p < n; p++) begin
            send_packet(job_table[0], TAG_W'(p), 1'b0);
        end
        repeat (NUM_ENGINES + 4) @(posedge ap_clk);
    endtask

    task automatic run_job(input job_t job);
        int unsigned writes_before;
        writes_before = writes_seen;
        @(posedge ap_clk);
        start_i     <= 1'b1;
        op_i        <= job.op;
        operand_i   <= job.operand;
        base_addr_i <= job.base;
        count_i     <= job.count;
        @(posedge ap_clk);
        start_i <= 1'b0;
        @(negedge ap_clk);
        check_value("done_o", done_o, 0);
        job_busy = 1'b1;
        for (int p = 0; p < int'(job.count); p++) begin
            send_packet(job, TAG_W'(p), 1'b1);
        end
        job_busy = 1'b0;
        do @(negedge ap_clk); while (!done_o);
        check_cond(exp_wr_data.num() == 0, "Expected memory writes were never requested");
        check_value("mem_req_valid_o count", writes_seen - writes_before, job.writes);
    endtask

    // ----------------------------------------
    // Memory model, in-order acks
    // ----------------------------------------
    initial begin : mem_responder
        logic [31:0] delay;
        int unsigned ack_wait;
        mem_ack_valid_i = 1'b0;
        mem_ack_id_i    = '0;
        ack_wait        = 0;
        forever begin
            @(posedge ap_clk);
            mem_ack_valid_i <= 1'b0;
            if (ack_wait != 0) begin
                ack_wait--;
            end else if (ack_q.size() != 0) begin
                mem_ack_valid_i <= 1'b1;
                mem_ack_id_i    <= ack_q.pop_front();
                draw_bits(lfsr_ack, 2, delay);
                ack_wait = delay;
            end
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge ap_clk) begin
        if (!areset_lane_template) begin
            if (lane_out_valid_o) begin
                check_cond(exp_out_data.size() != 0, "Output packet appeared with none expected");
                check_value("lane_out_data_o", lane_out_data_o, exp_out_data.pop_front());
                check_value("lane_out_tag_o", lane_out_tag_o, exp_out_tag.pop_front());
                check_value("lane_out_valid_o cycle", cycle, exp_out_cycle.pop_front());
            end
            if (mem_req_valid_o) begin
                check_cond(exp_wr_data.exists(mem_req_addr_o),
                           "Memory request to an address with no write pending");
                check_value("mem_req_data_o", mem_req_data_o, exp_wr_data[mem_req_addr_o]);
                check_value("mem_req_id_o", mem_req_id_o, exp_wr_id[mem_req_addr_o]);
                exp_wr_data.delete(mem_req_addr_o);
                exp_wr_id.delete(mem_req_addr_o);
                ack_q.push_back(mem_req_id_o);
                writes_seen++;
            end
            if (done_o) begin
                check_cond(!job_busy && exp_out_data.size() == 0 && exp_wr_data.num() == 0
                           && ack_q.size() == 0 && !mem_ack_valid_i,
                           "done_o high while packets or writes were still pending");
            end
        end
    end

    // Limit sized from the packets in the job table
    initial begin : watchdog
        int unsigned limit_cycles;
        wait (table_loaded);
        limit_cycles = 200;
        for (int j = 0; j < NUM_JOBS; j++) begin
            limit_cycles += int'(job_table[j].count) * (PKT_GAP + 2 + 4 * NUM_ENGINES) + 40;
        end
        #(limit_cycles * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run hung", limit_cycles);
        fail_run();
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : main
        areset_lane_template = 1'b1;
        start_i              = 1'b0;
        op_i                 = OP_PASS;
        operand_i            = '0;
        base_addr_i          = '0;
        count_i              = '0;
        lane_valid_i         = 1'b0;
        lane_data_i          = '0;
        lane_tag_i           = '0;
        load_job_table();
        repeat (2) @(posedge ap_clk);
        areset_lane_template <= 1'b0;
        @(negedge ap_clk);
        check_value("done_o", done_o, 0);
        check_value("lane_out_valid_o", lane_out_valid_o, 0);
        check_value("mem_req_valid_o", mem_req_valid_o, 0);

        // Idle state, then each job, then the done state
        send_dropped(3);
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(job_table[j]);
        end
        send_dropped(3);

        check_cond(exp_out_data.size() == 0, "Expected output packets never appeared");
        check_cond(ack_q.size() == 0, "Memory acknowledgements left unsent");
        $display("sim passed");
        $finish;
    end

endmodule

// ==== lane_overlay.f ====
source/lane_pkg.sv
source/lane_ctrl.sv
source/lane_engine.sv
source/mem_port.sv
source/lane_overlay.sv
sim/lane_overlay_sva.sv
sim/lane_overlay_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the lane overlay testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module lane_overlay_tb \
    -f lane_overlay.f \
    -Mdir obj_dir

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/Vlane_overlay_tb
